// File: include/baud_rates.svh
// baud divisor macros for the 24 MHz board clock
`ifndef BAUD_RATES_SVH
`define BAUD_RATES_SVH

// clock cycles per UART bit, rounded to the nearest whole cycle
`define BAUD_DIV_8M     3
`define BAUD_DIV_115200 208

`endif

// File: rtl/uart_pkg.sv
// UART line protocol types: parity mode, receiver status word, parity helper
package uart_pkg;

    // parity bit appended after the eight data bits, or none at all
    typedef enum logic [1:0] {
        PARITY_NONE = 2'd0,
        PARITY_EVEN = 2'd1,
        PARITY_ODD  = 2'd2
    } parity_mode_t;

    // one received byte; the error flags are only meaningful while done is high
    typedef struct packed {
        logic [7:0] data;
        logic       done;
        logic       parity_error;
        logic       frame_error;
    } rx_status_t;

    // parity bit value that the transmitter sends for a byte
    // the receiver compares the sampled bit against the same function
    function automatic logic parity_of(input logic [7:0] data, input parity_mode_t mode);
        logic ones_odd;
        ones_odd = ^data;
        if (mode == PARITY_ODD) begin
            return ~ones_odd;
        end
        return ones_odd;
    endfunction

endpackage

// File: rtl/link_test_pkg.sv
// link self-test definitions: command codes, tester FSM states, LED drive word
package link_test_pkg;

    // command bytes understood by the modulation boards
    localparam logic [7:0] CMD_TURN_ON  = 8'hEE;
    localparam logic [7:0] CMD_TURN_OFF = 8'h55;
    localparam logic [7:0] CMD_TOGGLE   = 8'hC3;

    // phases of the self-test
    typedef enum logic [1:0] {
        ST_SETTLE = 2'd0,
        ST_SEND   = 2'd1,
        ST_WAIT   = 2'd2
    } test_state_t;

    // board status LEDs, wired active low
    typedef struct packed {
        logic red;
        logic green;
        logic blue;
    } led_drive_t;

    localparam logic LED_ON  = 1'b0;
    localparam logic LED_OFF = 1'b1;

    localparam led_drive_t LEDS_OFF = '{red: LED_OFF, green: LED_OFF, blue: LED_OFF};

endpackage

// File: rtl/baud_tick_gen.sv
// restartable baud divider with bit tick and mid-bit tick
`timescale 1ns/1ps

module baud_tick_gen #(
    parameter int unsigned BAUD_DIV = 3
) (
    input  logic clk,
    input  logic rst_n,
    input  logic restart,
    output logic bit_tick,
    output logic mid_tick
);

    localparam int CNT_W = (BAUD_DIV > 2) ? $clog2(BAUD_DIV) : 1;

    // the mid tick comes one cycle before the true half of the bit
    // so that a receiver, which sees the start edge a cycle late, samples near the centre
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(BAUD_DIV - 1);
    localparam logic [CNT_W-1:0] MID_CNT  = CNT_W'(BAUD_DIV / 2 - 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (restart || cnt == LAST_CNT) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // both ticks come straight from the count, one cycle wide each
    assign bit_tick = (cnt == LAST_CNT);
    assign mid_tick = (cnt == MID_CNT);

endmodule

// File: rtl/uart_tx.sv
// UART transmitter: start bit, eight data bits LSB first, optional parity, stop bit
`timescale 1ns/1ps

module uart_tx import uart_pkg::*; #(
    parameter int unsigned  BAUD_DIV = 3,
    parameter parity_mode_t PARITY   = PARITY_NONE
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] tx_data,
    input  logic       start,
    output logic       tx,
    output logic       busy
);

    // index of the stop bit, counting the start bit as index 0
    localparam logic [3:0] LAST_BIT = (PARITY == PARITY_NONE) ? 4'd10 - 4'd1 : 4'd10;

    logic       accept;
    logic       bit_tick;
    logic       top_bit;
    logic [3:0] bit_idx;
    logic [9:0] shreg;

    // a level on start is enough, the byte is taken whenever the line is free
    assign accept = start && !busy;

    // with parity off the slot above the data holds a second stop level,
    // which is never shifted out because the frame ends one bit earlier
    assign top_bit = (PARITY == PARITY_NONE) ? 1'b1 : parity_of(tx_data, PARITY);

    // the divider restarts on accept so the start bit lasts a full bit time
    baud_tick_gen #(
        .BAUD_DIV(BAUD_DIV)
    ) u_baud (
        .clk     (clk),
        .rst_n   (rst_n),
        .restart (accept),
        .bit_tick(bit_tick),
        .mid_tick()
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx      <= 1'b1;
            busy    <= 1'b0;
            bit_idx <= '0;
        end else if (accept) begin
            tx      <= 1'b0;
            busy    <= 1'b1;
            bit_idx <= '0;
        end else if (busy && bit_tick) begin
            if (bit_idx == LAST_BIT) begin
                // stop bit has lasted its full bit time, tx stays high
                busy <= 1'b0;
            end else begin
                tx      <= shreg[0];
                bit_idx <= bit_idx + 1'b1;
            end
        end
    end

    // payload shift register: data, then parity or stop, then stop
    always_ff @(posedge clk) begin
        if (accept) begin
            shreg <= {1'b1, top_bit, tx_data};
        end else if (busy && bit_tick) begin
            shreg <= {1'b1, shreg[9:1]};
        end
    end

endmodule

// File: rtl/uart_rx.sv
// UART receiver: input synchronizer, start detection, mid-bit sampling, parity and stop checks
`timescale 1ns/1ps

module uart_rx import uart_pkg::*; #(
    parameter int unsigned  BAUD_DIV = 3,
    parameter parity_mode_t PARITY   = PARITY_NONE
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx,
    output rx_status_t status
);

    // stop bit index, start bit being index 0
    localparam logic [3:0] LAST_BIT = (PARITY == PARITY_NONE) ? 4'd9 : 4'd10;

    logic       rx_meta;
    logic       rx_sync;
    logic       rx_prev;
    logic       start_edge;
    logic       mid_tick;
    logic       active;
    logic [3:0] bit_idx;
    logic [7:0] shreg;
    logic       par_bit;
    logic       done_q;
    logic       perr_q;
    logic       ferr_q;

    // two flops against metastability, a third one for the edge detector
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // only a falling edge on an idle line opens a frame
    assign start_edge = !active && rx_prev && !rx_sync;

    baud_tick_gen #(
        .BAUD_DIV(BAUD_DIV)
    ) u_baud (
        .clk     (clk),
        .rst_n   (rst_n),
        .restart (start_edge),
        .bit_tick(),
        .mid_tick(mid_tick)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame control and checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active  <= 1'b0;
            bit_idx <= '0;
            done_q  <= 1'b0;
            perr_q  <= 1'b0;
            ferr_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (start_edge) begin
                active  <= 1'b1;
                bit_idx <= '0;
            end else if (active && mid_tick) begin
                if (bit_idx == 4'd0 && rx_sync) begin
                    // line went back high before mid start bit, treat it as a glitch
                    active <= 1'b0;
                end else if (bit_idx == LAST_BIT) begin
                    active <= 1'b0;
                    done_q <= 1'b1;
                    ferr_q <= !rx_sync;
                    perr_q <= (PARITY != PARITY_NONE) && (par_bit != parity_of(shreg, PARITY));
                end else begin
                    bit_idx <= bit_idx + 1'b1;
                end
            end
        end
    end

    // data bits arrive LSB first, so they shift in from the top
    always_ff @(posedge clk) begin
        if (active && mid_tick) begin
            if (bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
                shreg <= {rx_sync, shreg[7:1]};
            end
            if (bit_idx == 4'd9) begin
                par_bit <= rx_sync;
            end
        end
    end

    assign status = '{data: shreg, done: done_q, parity_error: perr_q, frame_error: ferr_q};

endmodule

// File: rtl/link_tester.sv
// link self-test FSM: settle, send and wait phases, echo comparison and LED drive
`timescale 1ns/1ps

module link_tester import uart_pkg::*, link_test_pkg::*; #(
    parameter int unsigned SETTLE_CYCLES = 12_000_000,
    parameter int unsigned SEND_CYCLES   = 48_000_000,
    parameter int unsigned WAIT_CYCLES   = 24_000_000
) (
    input  logic       clk,
    input  logic       rst_n,
    input  rx_status_t rx_status,
    input  logic       busy,
    output logic [7:0] tx_data,
    output logic       start,
    output led_drive_t leds
);

    localparam logic [31:0] SETTLE_LAST = 32'(SETTLE_CYCLES - 1);
    localparam logic [31:0] SEND_LAST   = 32'(SEND_CYCLES - 1);
    localparam logic [31:0] WAIT_LAST   = 32'(WAIT_CYCLES - 1);

    test_state_t state;
    logic [31:0] phase_cnt;
    logic        echo_good;

    // the transmitter sends frames back to back for as long as we stay in ST_SEND
    assign start = (state == ST_SEND);

    // the test byte may only change between frames
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_data <= CMD_TURN_ON;
        end else if (!busy) begin
            tx_data <= CMD_TURN_ON;
        end
    end

    // a good echo is the same byte with clean parity and stop bit
    assign echo_good = rx_status.done && !rx_status.parity_error && !rx_status.frame_error
                       && (rx_status.data == tx_data);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // phase sequencing with one shared counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_SETTLE;
            phase_cnt <= '0;
            leds      <= LEDS_OFF;
        end else begin
            case (state)
                ST_SETTLE: begin
                    // give the far side time to come up before anything is sent
                    if (phase_cnt == SETTLE_LAST) begin
                        state     <= ST_SEND;
                        phase_cnt <= '0;
                    end else begin
                        phase_cnt <= phase_cnt + 1'b1;
                    end
                end

                ST_SEND: begin
                    if (rx_status.done) begin
                        leds.red  <= echo_good ? LED_ON : LED_OFF;
                        leds.blue <= echo_good ? LED_OFF : LED_ON;
                    end
                    // the watchdog only runs out if no good echo shows up in time
                    if (echo_good) begin
                        phase_cnt <= '0;
                    end else if (phase_cnt == SEND_LAST) begin
                        state     <= ST_WAIT;
                        phase_cnt <= '0;
                    end else begin
                        phase_cnt <= phase_cnt + 1'b1;
                    end
                end

                ST_WAIT: begin
                    leds.blue <= LED_OFF;
                    if (phase_cnt == WAIT_LAST) begin
                        state     <= ST_SEND;
                        phase_cnt <= '0;
                    end else begin
                        phase_cnt <= phase_cnt + 1'b1;
                    end
                end

                default: begin
                    state     <= ST_SETTLE;
                    phase_cnt <= '0;
                end
            endcase
        end
    end

endmodule

// File: rtl/uart_link_top.sv
// UART link self-test top level: transmitter, receiver and link tester
`timescale 1ns/1ps
`include "baud_rates.svh"

module uart_link_top import uart_pkg::*, link_test_pkg::*; #(
    parameter int unsigned  BAUD_DIV      = `BAUD_DIV_8M,
    parameter parity_mode_t PARITY        = PARITY_NONE,
    parameter int unsigned  SETTLE_CYCLES = 12_000_000,
    parameter int unsigned  SEND_CYCLES   = 48_000_000,
    parameter int unsigned  WAIT_CYCLES   = 24_000_000
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx,
    output logic       tx,
    output led_drive_t leds
);

    logic [7:0] tx_data;
    logic       start;
    logic       busy;
    rx_status_t rx_status;

    // both ends of the line must agree on baud rate and parity
    uart_tx #(
        .BAUD_DIV(BAUD_DIV),
        .PARITY  (PARITY)
    ) u_tx (
        .clk    (clk),
        .rst_n  (rst_n),
        .tx_data(tx_data),
        .start  (start),
        .tx     (tx),
        .busy   (busy)
    );

    uart_rx #(
        .BAUD_DIV(BAUD_DIV),
        .PARITY  (PARITY)
    ) u_rx (
        .clk   (clk),
        .rst_n (rst_n),
        .rx    (rx),
        .status(rx_status)
    );

    link_tester #(
        .SETTLE_CYCLES(SETTLE_CYCLES),
        .SEND_CYCLES  (SEND_CYCLES),
        .WAIT_CYCLES  (WAIT_CYCLES)
    ) u_tester (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_status(rx_status),
        .busy     (busy),
        .tx_data  (tx_data),
        .start    (start),
        .leds     (leds)
    );

endmodule

// File: tests/uart_link_asserts.sv
// bound assertions on the UART link top level: idle line, done width, start gating, green LED
`timescale 1ns/1ps

module uart_link_asserts import uart_pkg::*, link_test_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input logic        tx,
    input logic        busy,
    input logic        start,
    input rx_status_t  rx_status,
    input test_state_t state,
    input led_drive_t  leds
);

    // read by the testbench at the end of the run
    int fail_count = 0;

    // the line idles high between frames
    a_tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n) !busy |-> tx)
        else begin
            fail_count++;
            $error("tx low while the transmitter is not busy");
        end

    a_done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        rx_status.done |=> !rx_status.done)
        else begin
            fail_count++;
            $error("receiver done held for more than one cycle");
        end

    // nothing is sent while settling or pausing
    a_start_gated: assert property (@(posedge clk) disable iff (!rst_n)
        (state == ST_SETTLE || state == ST_WAIT) |-> !start)
        else begin
            fail_count++;
            $error("start high outside the send phase");
        end

    a_green_off: assert property (@(posedge clk) disable iff (!rst_n) leds.green == LED_OFF)
        else begin
            fail_count++;
            $error("spare green LED was lit");
        end

endmodule

bind uart_link_top uart_link_asserts i_asserts (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx       (tx),
    .busy     (busy),
    .start    (start),
    .rx_status(rx_status),
    .state    (u_tester.state),
    .leds     (leds)
);

// File: tests/tb_uart_link.sv
// testbench for the UART link self-test: loopback, fault injection, frame decoder, LED checks
`timescale 1ns/1ps

module tb_uart_link import uart_pkg::*, link_test_pkg::*; ();

    localparam int BAUD_DIV      = 4;
    localparam int SETTLE_CYCLES = 20;
    localparam int SEND_CYCLES   = 400;
    localparam int WAIT_CYCLES   = 100;
    localparam int FRAME_CYCLES  = 11 * BAUD_DIV;
    localparam int CHECK_DELAY   = FRAME_CYCLES + BAUD_DIV + 4;
    localparam int FAULT_NONE    = 0;
    localparam int FAULT_DATA    = 1;
    localparam int FAULT_PARITY  = 2;

    logic       clk;
    logic       rst_n;
    logic       rx;
    logic       tx;
    led_drive_t leds;

    int          seed;
    int          cycle = 0;
    int          pos;
    int          idle_cnt;
    int          starts = 0;
    int          frames_seen = 0;
    int          pauses = 0;
    int          max_gap = 0;
    int          settle_idle = 0;
    int          last_pause = 0;
    int          fault_mode;
    int          frame_fault;
    int          fault_bit;
    int          frame_start;
    int          last_start = -1;
    logic        in_frame;
    logic        inject;
    logic [10:0] frame_bits;
    logic [7:0]  echo_data;
    logic        echo_par;
    int          due_q[$];
    int          start_q[$];
    led_drive_t  exp_q[$];

    uart_link_top #(
        .BAUD_DIV     (BAUD_DIV),
        .PARITY       (PARITY_EVEN),
        .SETTLE_CYCLES(SETTLE_CYCLES),
        .SEND_CYCLES  (SEND_CYCLES),
        .WAIT_CYCLES  (WAIT_CYCLES)
    ) i_dut (
        .clk  (clk),
        .rst_n(rst_n),
        .rx   (rx),
        .tx   (tx),
        .leds (leds)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[ERROR] time %0t: %s is %0h, expected %0h", $time, name, got, expected);
            $display("TEST FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic fail_run(input string msg);
        $display("%s at time %0t", msg, $time);
        $display("TEST FAILED");
        $fatal(1, "stopped on a failure");
    endtask

    // active-low LED pattern the tester must show for one echoed frame
    function automatic led_drive_t expected_leds(input logic [7:0] data, input logic par,
                                                 input logic stop);
        logic       good;
        led_drive_t l;
        good    = (data == CMD_TURN_ON) && !(^{data, par}) && stop;
        l.green = 1'b1;
        l.red   = good ? 1'b0 : 1'b1;
        l.blue  = good ? 1'b1 : 1'b0;
        return l;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // loopback with fault injection, and the frame decoder on tx
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk) begin
        if (!rst_n) begin
            rx       = 1'b1;
            in_frame = 1'b0;
            idle_cnt = 0;
        end else begin
            if (in_frame) begin
                pos = pos + 1;
            end else if (tx == 1'b0) begin
                // a new frame starts here and keeps the fault mode chosen now
                in_frame    = 1'b1;
                pos         = 0;
                frame_start = cycle;
                last_start  = cycle;
                if (starts == 0) begin
                    settle_idle = idle_cnt;
                end else begin
                    if (idle_cnt > max_gap) begin
                        max_gap = idle_cnt;
                    end
                    if (idle_cnt > 2 * BAUD_DIV) begin
                        pauses++;
                        last_pause = idle_cnt;
                    end
                end
                starts++;
                idle_cnt    = 0;
                frame_fault = fault_mode;
                fault_bit   = 9;
                if (fault_mode == FAULT_DATA) begin
                    fault_bit = 1 + int'($unsigned($random(seed)) % 8);
                end
            end else begin
                idle_cnt++;
                if (starts > 0 && idle_cnt == WAIT_CYCLES / 2) begin
                    check_value("leds.blue in pause", 32'(leds.blue), 32'(LED_OFF));
                end
            end

            inject = in_frame && (frame_fault != FAULT_NONE) && (pos / BAUD_DIV == fault_bit);
            rx     = tx ^ inject;

            if (in_frame && pos % BAUD_DIV == BAUD_DIV / 2) begin
                frame_bits[pos / BAUD_DIV] = tx;
            end
            if (in_frame && pos == FRAME_CYCLES - BAUD_DIV / 2) begin
                check_value("tx start bit", 32'(frame_bits[0]), 32'd0);
                check_value("tx data", 32'(frame_bits[8:1]), 32'(CMD_TURN_ON));
                check_value("tx even parity", 32'(frame_bits[9]), 32'(^frame_bits[8:1]));
                check_value("tx stop bit", 32'(frame_bits[10]), 32'd1);
                echo_data = frame_bits[8:1];
                echo_par  = frame_bits[9];
                if (frame_fault == FAULT_DATA) begin
                    echo_data[fault_bit - 1] = ~echo_data[fault_bit - 1];
                end else if (frame_fault == FAULT_PARITY) begin
                    echo_par = ~echo_par;
                end
                due_q.push_back(frame_start + CHECK_DELAY);
                start_q.push_back(frame_start);
                exp_q.push_back(expected_leds(echo_data, echo_par, frame_bits[10]));
                frames_seen++;
            end
            if (in_frame && pos == FRAME_CYCLES - 1) begin
                in_frame = 1'b0;
            end
        end
    end

    // LED compare after each echo
    // a frame with no successor was the last one before the tester paused
    always @(negedge clk) begin
        if (due_q.size() > 0 && cycle == due_q[0]) begin
            void'(due_q.pop_front());
            if (last_start != start_q.pop_front()) begin
                check_value("leds", 32'(leds), 32'(exp_q.pop_front()));
            end else begin
                void'(exp_q.pop_front());
                check_value("leds.blue after pause", 32'(leds.blue), 32'(LED_OFF));
            end
        end
    end

    task automatic wait_frames(input int n, input int limit);
        int target;
        int waited;
        target = frames_seen + n;
        waited = 0;
        while (frames_seen < target) begin
            @(negedge clk);
            waited++;
            if (waited > limit) fail_run("timeout waiting for frames on tx");
        end
    endtask

    task automatic wait_idle(input int limit);
        int waited;
        waited = 0;
        while (in_frame || idle_cnt <= 2 * BAUD_DIV) begin
            @(negedge clk);
            waited++;
            if (waited > limit) fail_run("timeout waiting for the tester to pause");
        end
    endtask

    task automatic wait_resume(input int limit);
        int p0;
        int waited;
        p0     = pauses;
        waited = 0;
        while (pauses == p0) begin
            @(negedge clk);
            waited++;
            if (waited > limit) fail_run("timeout waiting for sending to resume");
        end
        // the pause may begin while the last frame is still on the line
        if (last_pause < WAIT_CYCLES - FRAME_CYCLES || last_pause > WAIT_CYCLES + 2 * BAUD_DIV)
            fail_run("pause length on tx is out of range");
    endtask

    task automatic drain_checks(input int limit);
        int waited;
        waited = 0;
        while (due_q.size() > 0) begin
            @(negedge clk);
            waited++;
            if (waited > limit) fail_run("timeout waiting for pending LED checks");
        end
    endtask

    initial begin
        seed       = 23464;
        clk        = 1'b0;
        rst_n      = 1'b0;
        rx         = 1'b1;
        fault_mode = FAULT_NONE;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        check_value("leds after reset", 32'(leds), 32'(LEDS_OFF));

        wait_frames(1, SETTLE_CYCLES + 4 * FRAME_CYCLES);
        if (settle_idle < SETTLE_CYCLES) fail_run("tx started before the settle period ended");

        // clean loopback for longer than the watchdog period
        max_gap = 0;
        wait_frames(12 + int'($unsigned($random(seed)) % 4), 20 * FRAME_CYCLES);
        if (max_gap > 2 * BAUD_DIV) fail_run("idle gap between frames too long");

        fault_mode = FAULT_DATA;
        wait_idle(2 * SEND_CYCLES);
        fault_mode = FAULT_PARITY;
        wait_resume(2 * WAIT_CYCLES);

        wait_idle(2 * SEND_CYCLES);
        fault_mode = FAULT_NONE;
        wait_resume(2 * WAIT_CYCLES);

        wait_frames(3, 5 * FRAME_CYCLES);
        drain_checks(2 * CHECK_DELAY);

        if (i_dut.i_asserts.fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+include
rtl/uart_pkg.sv
rtl/link_test_pkg.sv
rtl/baud_tick_gen.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/link_tester.sv
rtl/uart_link_top.sv
tests/uart_link_asserts.sv
tests/tb_uart_link.sv

// File: Makefile
SIM  := obj_dir/Vtb_uart_link
SRCS := $(shell grep -v '^+' build.f) include/baud_rates.svh

.PHONY: run clean

$(SIM): $(SRCS) build.f
	verilator --binary --timing --assert --top-module tb_uart_link -f build.f

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q '^TEST OK$$' sim.log

clean:
	rm -rf obj_dir sim.log
